//--- rtl/qoi_cfg.svh
`ifndef QOI_CFG_SVH
`define QOI_CFG_SVH

// ******************************
// colour index and run limits
// ******************************
`define QOI_INDEX_SIZE     64
`define QOI_RUN_MAX        62

// ******************************
// link credits and widths
// ******************************
`define QOI_PIX_CREDITS    4     // depth of the pixel input buffer
`define QOI_CHUNK_CREDITS  2     // depth of the internal chunk buffer
`define QOI_BYTE_CREDITS   4     // slots the byte sink offers after reset
`define QOI_COUNT_W        24
`define QOI_REG_ADDR_W     2
`define QOI_REG_DATA_W     32

// register map
`define QOI_REG_CTRL       2'd0
`define QOI_REG_STATUS     2'd1
`define QOI_REG_PIXELS     2'd2
`define QOI_REG_BYTES      2'd3

`endif

//--- rtl/qoi_pkg.sv
`default_nettype none

package qoi_pkg;

    // ******************************
    // pixel and chunk types
    // ******************************
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] a;
    } pixel_t;

    typedef enum logic [2:0] {
        OP_INDEX = 3'd0,
        OP_DIFF  = 3'd1,
        OP_LUMA  = 3'd2,
        OP_RUN   = 3'd3,
        OP_RGB   = 3'd4,
        OP_RGBA  = 3'd5
    } qoi_op_t;

    // data[0] is the first byte on the wire
    typedef struct packed {
        logic [4:0][7:0] data;
        logic [2:0]      len;     // 1 to 5 valid bytes
        logic            last;    // final chunk of the image
    } chunk_t;

endpackage

`default_nettype wire

//--- rtl/qoi_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "qoi_cfg.svh"

module qoi_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       reg_we_i,
    input  logic [`QOI_REG_ADDR_W-1:0] reg_addr_i,
    input  logic [`QOI_REG_DATA_W-1:0] reg_wdata_i,
    output logic [`QOI_REG_DATA_W-1:0] reg_rdata_o,
    output logic                       start_o,
    output logic [`QOI_COUNT_W-1:0]    pixel_count_o,
    input  logic                       image_end_i,
    input  logic                       serializer_idle_i,
    input  logic                       byte_fire_i
);

    logic                    busy;
    logic                    done;
    logic                    ctrl_start;
    logic                    pix_wr;
    logic [`QOI_COUNT_W-1:0] byte_count;

    assign ctrl_start = reg_we_i && (reg_addr_i == `QOI_REG_CTRL) && reg_wdata_i[0];
    assign pix_wr     = reg_we_i && (reg_addr_i == `QOI_REG_PIXELS);

    always_ff @(posedge clk) begin
        if (rst) begin
            start_o       <= 1'b0;
            busy          <= 1'b0;
            done          <= 1'b0;
            pixel_count_o <= '0;
            byte_count    <= '0;
        end else begin
            start_o <= ctrl_start;
            if (pix_wr) begin
                pixel_count_o <= reg_wdata_i[`QOI_COUNT_W-1:0];
            end
            if (ctrl_start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy && !start_o && image_end_i && serializer_idle_i) begin
                busy <= 1'b0;  // image_end_i still holds the old image during start_o
                done <= 1'b1;
            end
            if (start_o) begin
                byte_count <= '0;
            end else if (byte_fire_i) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr_i)
            `QOI_REG_STATUS: reg_rdata_o = {30'd0, done, busy};
            `QOI_REG_PIXELS: reg_rdata_o = `QOI_REG_DATA_W'(pixel_count_o);
            `QOI_REG_BYTES:  reg_rdata_o = `QOI_REG_DATA_W'(byte_count);
            default:         reg_rdata_o = '0;  // control reads back as zero
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/qoi_credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module qoi_credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     not_empty_o,
    output logic     credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop_ok;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty_o = (count != '0);
    assign pop_ok      = pop_i && not_empty_o;
    assign pop_data_o  = mem[rd_ptr];
    assign credit_o    = pop_ok;  // slot is free again as soon as it is read

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sender holds credits, so a push never finds the buffer full
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/qoi_classify.sv
`timescale 1ns/100ps
`default_nettype none
`include "qoi_cfg.svh"

module qoi_classify (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  logic [`QOI_COUNT_W-1:0] pixel_count_i,
    input  logic                    pix_avail_i,
    input  qoi_pkg::pixel_t         pix_data_i,
    output logic                    pix_pop_o,
    output logic                    chunk_push_o,
    output qoi_pkg::chunk_t         chunk_data_o,
    input  logic                    chunk_credit_i,
    output logic                    image_end_o
);

    localparam int IDX_W  = $clog2(`QOI_INDEX_SIZE);
    localparam int CRED_W = $clog2(`QOI_CHUNK_CREDITS + 1);
    localparam qoi_pkg::pixel_t START_PX = '{r: 8'h00, g: 8'h00, b: 8'h00, a: 8'hff};

    qoi_pkg::pixel_t            prev_px;
    qoi_pkg::pixel_t            idx_mem [`QOI_INDEX_SIZE];
    logic [`QOI_INDEX_SIZE-1:0] idx_valid;
    qoi_pkg::pixel_t            idx_entry;
    logic [IDX_W-1:0]           idx_pos;
    logic [7:0]                 hash_sum;
    logic [5:0]                 run_len;
    logic [5:0]                 run_next;
    logic [5:0]                 run_out;
    logic [`QOI_COUNT_W-1:0]    pix_cnt;
    logic [`QOI_COUNT_W-1:0]    last_cnt;
    logic [CRED_W-1:0]          credits;
    logic                       active;
    logic                       can_step;
    logic                       same_px;
    logic                       flush_run;
    logic                       is_last;
    logic                       chunk_last;
    logic                       diff_ok;
    logic                       luma_ok;
    logic signed [7:0]          dr;
    logic signed [7:0]          dg;
    logic signed [7:0]          db;
    logic signed [7:0]          dr_dg;
    logic signed [7:0]          db_dg;
    qoi_pkg::qoi_op_t           sel_op;

    // ******************************
    // index lookup and differences
    // ******************************
    assign hash_sum  = pix_data_i.r * 8'd3 + pix_data_i.g * 8'd5 +
                       pix_data_i.b * 8'd7 + pix_data_i.a * 8'd11;
    assign idx_pos   = hash_sum[IDX_W-1:0];  // only the low bits matter for mod 64
    assign idx_entry = idx_valid[idx_pos] ? idx_mem[idx_pos] : '0;

    assign dr    = pix_data_i.r - prev_px.r;
    assign dg    = pix_data_i.g - prev_px.g;
    assign db    = pix_data_i.b - prev_px.b;
    assign dr_dg = dr - dg;
    assign db_dg = db - dg;

    assign diff_ok = (dr >= -8'sd2) && (dr <= 8'sd1) && (dg >= -8'sd2) && (dg <= 8'sd1) &&
                     (db >= -8'sd2) && (db <= 8'sd1);
    assign luma_ok = (dg >= -8'sd32) && (dg <= 8'sd31) &&
                     (dr_dg >= -8'sd8) && (dr_dg <= 8'sd7) &&
                     (db_dg >= -8'sd8) && (db_dg <= 8'sd7);

    // ******************************
    // step control
    // ******************************
    assign last_cnt  = pixel_count_i - 1'b1;
    assign is_last   = (pix_cnt == last_cnt);
    assign same_px   = (pix_data_i == prev_px);
    assign flush_run = !same_px && (run_len != '0);  // pixel stays put for a second cycle
    assign run_next  = run_len + 6'd1;
    assign run_out   = same_px ? run_next : run_len;
    assign can_step  = active && !start_i && pix_avail_i && (credits != '0);

    assign pix_pop_o    = can_step && !flush_run;
    assign chunk_push_o = can_step && (!same_px || run_next == 6'(`QOI_RUN_MAX) || is_last);
    assign chunk_last   = !flush_run && is_last;

    always_comb begin
        if (same_px || flush_run) begin
            sel_op = qoi_pkg::OP_RUN;
        end else if (pix_data_i == idx_entry) begin
            sel_op = qoi_pkg::OP_INDEX;
        end else if (pix_data_i.a != prev_px.a) begin
            sel_op = qoi_pkg::OP_RGBA;
        end else if (diff_ok) begin
            sel_op = qoi_pkg::OP_DIFF;
        end else if (luma_ok) begin
            sel_op = qoi_pkg::OP_LUMA;
        end else begin
            sel_op = qoi_pkg::OP_RGB;
        end
    end

    always_comb begin
        chunk_data_o      = '0;
        chunk_data_o.last = chunk_last;
        case (sel_op)
            qoi_pkg::OP_RUN: begin
                chunk_data_o.data[0] = {2'b11, run_out - 6'd1};  // stored with a bias of 1
                chunk_data_o.len     = 3'd1;
            end
            qoi_pkg::OP_INDEX: begin
                chunk_data_o.data[0] = {2'b00, idx_pos};
                chunk_data_o.len     = 3'd1;
            end
            qoi_pkg::OP_DIFF: begin
                chunk_data_o.data[0] = {2'b01, 2'(dr + 8'sd2), 2'(dg + 8'sd2), 2'(db + 8'sd2)};
                chunk_data_o.len     = 3'd1;
            end
            qoi_pkg::OP_LUMA: begin
                chunk_data_o.data[0] = {2'b10, 6'(dg + 8'sd32)};
                chunk_data_o.data[1] = {4'(dr_dg + 8'sd8), 4'(db_dg + 8'sd8)};
                chunk_data_o.len     = 3'd2;
            end
            qoi_pkg::OP_RGBA: begin
                chunk_data_o.data = {pix_data_i.a, pix_data_i.b, pix_data_i.g, pix_data_i.r,
                                     8'hff};
                chunk_data_o.len  = 3'd5;
            end
            default: begin
                chunk_data_o.data = {8'h00, pix_data_i.b, pix_data_i.g, pix_data_i.r, 8'hfe};
                chunk_data_o.len  = 3'd4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            image_end_o <= 1'b0;
            prev_px     <= START_PX;
            run_len     <= '0;
            pix_cnt     <= '0;
            idx_valid   <= '0;
            credits     <= CRED_W'(`QOI_CHUNK_CREDITS);
        end else begin
            case ({chunk_push_o, chunk_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (start_i) begin
                active      <= 1'b1;
                image_end_o <= 1'b0;
                prev_px     <= START_PX;
                run_len     <= '0;
                pix_cnt     <= '0;
                idx_valid   <= '0;
            end else if (can_step) begin
                run_len <= (same_px && !chunk_push_o) ? run_next : 6'd0;
                if (pix_pop_o) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
                if (pix_pop_o && !same_px) begin
                    prev_px            <= pix_data_i;
                    idx_valid[idx_pos] <= 1'b1;
                end
                if (chunk_push_o && chunk_last) begin
                    active      <= 1'b0;
                    image_end_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_pop_o && !same_px) begin
            idx_mem[idx_pos] <= pix_data_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/qoi_chunk_serializer.sv
`timescale 1ns/100ps
`default_nettype none
`include "qoi_cfg.svh"

module qoi_chunk_serializer (
    input  logic            clk,
    input  logic            rst,
    input  logic            chunk_avail_i,
    input  qoi_pkg::chunk_t chunk_data_i,
    output logic            chunk_pop_o,
    output logic            byte_valid_o,
    output logic [7:0]      byte_data_o,
    input  logic            byte_credit_i,
    output logic            idle_o
);

    localparam int CRED_W = $clog2(`QOI_BYTE_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic [2:0]        byte_pos;
    logic              send;
    logic              last_byte;

    // ******************************
    // byte sequencing
    // ******************************
    assign send        = chunk_avail_i && (credits != '0);
    assign last_byte   = (byte_pos == chunk_data_i.len - 3'd1);
    assign chunk_pop_o = send && last_byte;  // head of the buffer is the loaded chunk
    assign idle_o      = !chunk_avail_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits      <= CRED_W'(`QOI_BYTE_CREDITS);
            byte_pos     <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= send;
            if (send) begin
                byte_pos <= last_byte ? 3'd0 : byte_pos + 3'd1;
            end
            case ({send, byte_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            byte_data_o <= chunk_data_i.data[byte_pos];
        end
    end

endmodule

`default_nettype wire

//--- rtl/qoi_encoder_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "qoi_cfg.svh"

module qoi_encoder_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       reg_we_i,
    input  logic [`QOI_REG_ADDR_W-1:0] reg_addr_i,
    input  logic [`QOI_REG_DATA_W-1:0] reg_wdata_i,
    output logic [`QOI_REG_DATA_W-1:0] reg_rdata_o,
    input  logic                       pix_valid_i,
    input  qoi_pkg::pixel_t            pix_data_i,
    output logic                       pix_credit_o,
    output logic                       byte_valid_o,
    output logic [7:0]                 byte_data_o,
    input  logic                       byte_credit_i
);

    logic                    start;
    logic [`QOI_COUNT_W-1:0] pixel_count;
    logic                    image_end;
    logic                    ser_idle;
    logic                    pix_avail;
    logic                    pix_pop;
    qoi_pkg::pixel_t         pix_head;
    logic                    chunk_push;
    qoi_pkg::chunk_t         chunk_in;
    logic                    chunk_avail;
    logic                    chunk_pop;
    qoi_pkg::chunk_t         chunk_head;
    logic                    chunk_credit;

    // ******************************
    // control, buffers, datapath
    // ******************************
    qoi_regs u_regs (
        .clk(clk), .rst(rst),
        .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .reg_rdata_o(reg_rdata_o),
        .start_o(start), .pixel_count_o(pixel_count),
        .image_end_i(image_end), .serializer_idle_i(ser_idle),
        .byte_fire_i(byte_valid_o)
    );

    qoi_credit_fifo #(.payload_t(qoi_pkg::pixel_t), .DEPTH(`QOI_PIX_CREDITS)) u_pix_fifo (
        .clk(clk), .rst(rst),
        .push_i(pix_valid_i), .push_data_i(pix_data_i),
        .pop_i(pix_pop), .pop_data_o(pix_head),
        .not_empty_o(pix_avail), .credit_o(pix_credit_o)
    );

    qoi_classify u_classify (
        .clk(clk), .rst(rst),
        .start_i(start), .pixel_count_i(pixel_count),
        .pix_avail_i(pix_avail), .pix_data_i(pix_head), .pix_pop_o(pix_pop),
        .chunk_push_o(chunk_push), .chunk_data_o(chunk_in),
        .chunk_credit_i(chunk_credit), .image_end_o(image_end)
    );

    qoi_credit_fifo #(.payload_t(qoi_pkg::chunk_t), .DEPTH(`QOI_CHUNK_CREDITS)) u_chunk_fifo (
        .clk(clk), .rst(rst),
        .push_i(chunk_push), .push_data_i(chunk_in),
        .pop_i(chunk_pop), .pop_data_o(chunk_head),
        .not_empty_o(chunk_avail), .credit_o(chunk_credit)
    );

    qoi_chunk_serializer u_serializer (
        .clk(clk), .rst(rst),
        .chunk_avail_i(chunk_avail), .chunk_data_i(chunk_head), .chunk_pop_o(chunk_pop),
        .byte_valid_o(byte_valid_o), .byte_data_o(byte_data_o),
        .byte_credit_i(byte_credit_i), .idle_o(ser_idle)
    );

endmodule

`default_nettype wire

//--- tb/qoi_ref_model.svh
`ifndef QOI_REF_MODEL_SVH
`define QOI_REF_MODEL_SVH

typedef qoi_pkg::pixel_t pixel_q_t[$];
typedef logic [7:0]      byte_q_t[$];

// ******************************
// reference QOI chunk encoder
// ******************************
function automatic byte_q_t qoi_encode_ref(input pixel_q_t pixels);
    byte_q_t         out;
    qoi_pkg::pixel_t seen [`QOI_INDEX_SIZE];
    qoi_pkg::pixel_t prev;
    qoi_pkg::pixel_t px;
    int              run;
    int              pos;
    byte             dr;
    byte             dg;
    byte             db;
    for (int i = 0; i < `QOI_INDEX_SIZE; i++) begin
        seen[i] = '0;
    end
    prev = 32'h000000ff;
    run  = 0;
    foreach (pixels[i]) begin
        px = pixels[i];
        if (px == prev) begin
            run++;
            if (run == `QOI_RUN_MAX || i == pixels.size() - 1) begin
                out.push_back(8'(8'hc0 + run - 1));  // run length is stored minus one
                run = 0;
            end
            continue;
        end
        if (run > 0) begin
            out.push_back(8'(8'hc0 + run - 1));
            run = 0;
        end
        pos = (3 * px.r + 5 * px.g + 7 * px.b + 11 * px.a) % `QOI_INDEX_SIZE;
        dr  = px.r - prev.r;  // differences wrap to a signed byte
        dg  = px.g - prev.g;
        db  = px.b - prev.b;
        if (seen[pos] == px) begin
            out.push_back(8'(pos));
        end else if (px.a != prev.a) begin
            out.push_back(8'hff);
            out.push_back(px.r);
            out.push_back(px.g);
            out.push_back(px.b);
            out.push_back(px.a);
        end else if (dr >= -2 && dr <= 1 && dg >= -2 && dg <= 1 && db >= -2 && db <= 1) begin
            out.push_back(8'(64 + (dr + 2) * 16 + (dg + 2) * 4 + (db + 2)));
        end else if (dg >= -32 && dg <= 31 && dr - dg >= -8 && dr - dg <= 7 &&
                     db - dg >= -8 && db - dg <= 7) begin
            out.push_back(8'(128 + dg + 32));
            out.push_back(8'((dr - dg + 8) * 16 + (db - dg + 8)));
        end else begin
            out.push_back(8'hfe);
            out.push_back(px.r);
            out.push_back(px.g);
            out.push_back(px.b);
        end
        seen[pos] = px;
        prev      = px;
    end
    return out;
endfunction

`endif

//--- tb/tb_qoi_encoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "qoi_cfg.svh"

module tb_qoi_encoder;

    localparam int CLK_PERIOD      = 20;
    localparam int PALETTE_PIXELS  = 200;
    localparam int UNIFORM_PIXELS  = 150;
    localparam int TOTAL_PIXELS    = 3 * PALETTE_PIXELS + UNIFORM_PIXELS;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_PIXELS + 1000;

    `include "qoi_ref_model.svh"

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       reg_we_i;
    logic [`QOI_REG_ADDR_W-1:0] reg_addr_i;
    logic [`QOI_REG_DATA_W-1:0] reg_wdata_i;
    logic [`QOI_REG_DATA_W-1:0] reg_rdata_o;
    logic                       pix_valid_i;
    qoi_pkg::pixel_t            pix_data_i;
    logic                       pix_credit_o;
    logic                       byte_valid_o;
    logic [7:0]                 byte_data_o;
    logic                       byte_credit_i;

    string    test_name;
    pixel_q_t src_pixels;
    byte_q_t  exp_bytes;
    int       rx_count         = 0;
    int       rx_base          = 0;
    int       credit_delay_max = 0;

    qoi_encoder_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input longint expected,
                                   input longint actual);
        fail_run($sformatf("Error: test %s, %s: expected 0x%0h, actual 0x%0h",
                           test_name, what, expected, actual));
    endtask

    task automatic check_value(input string what, input longint expected, input longint actual);
        assert (actual == expected) else report_mismatch(what, expected, actual);
    endtask

    task automatic write_reg(input logic [`QOI_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_we_i = 1'b0;
    endtask

    task automatic read_reg(input logic [`QOI_REG_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        reg_addr_i = addr;
        #1;
        data = reg_rdata_o;  // read data is combinational from the address
    endtask

    // ******************************
    // stimulus generation
    // ******************************
    function automatic pixel_q_t palette_image(input int n);
        pixel_q_t        img;
        qoi_pkg::pixel_t palette [8];
        qoi_pkg::pixel_t px;
        int              step;
        for (int i = 0; i < 8; i++) begin
            palette[i]   = $urandom;
            palette[i].a = (i < 6) ? 8'hff : 8'($urandom_range(0, 254));
        end
        px = palette[0];
        for (int i = 0; i < n; i++) begin
            step = int'($urandom_range(0, 40)) - 20;
            case ($urandom_range(0, 9))
                2, 3: px = palette[$urandom_range(0, 7)];
                4, 5: begin
                    px.r = px.r + 8'($urandom_range(0, 3)) - 8'd2;
                    px.g = px.g + 8'($urandom_range(0, 3)) - 8'd2;
                    px.b = px.b + 8'($urandom_range(0, 3)) - 8'd2;
                end
                6, 7: begin
                    px.g = px.g + 8'(step);
                    px.r = px.r + 8'(step + int'($urandom_range(0, 15)) - 8);
                    px.b = px.b + 8'(step + int'($urandom_range(0, 15)) - 8);
                end
                8: px.a = 8'($urandom);
                9: begin
                    px.r = 8'($urandom);
                    px.g = 8'($urandom);
                    px.b = 8'($urandom);
                end
                default: ;  // repeat the pixel so that runs appear
            endcase
            img.push_back(px);
        end
        return img;
    endfunction

    // ******************************
    // links and checking
    // ******************************
    initial begin
        int credits;
        int sent;
        credits     = `QOI_PIX_CREDITS;
        sent        = 0;
        pix_valid_i = 1'b0;
        pix_data_i  = '0;
        forever begin
            @(negedge clk);
            pix_valid_i = 1'b0;
            if (credits > 0 && sent < src_pixels.size()) begin
                pix_valid_i = 1'b1;
                pix_data_i  = src_pixels[sent];
                sent++;
                credits--;
            end
            if (pix_credit_o) begin
                credits++;  // slot freed this cycle, used from the next one on
                assert (credits <= `QOI_PIX_CREDITS)
                else fail_run("the DUT returned a pixel credit for a slot that was not in use");
            end
        end
    end

    initial begin
        int held;
        int release_wait;
        held          = 0;
        release_wait  = 0;
        byte_credit_i = 1'b0;
        forever begin
            @(negedge clk);
            byte_credit_i = 1'b0;
            if (held > 0) begin
                if (release_wait == 0) begin
                    byte_credit_i = 1'b1;
                    held--;
                    release_wait = int'($urandom_range(0, credit_delay_max));
                end else begin
                    release_wait--;
                end
            end
            if (byte_valid_o) begin
                held++;
                assert (held <= `QOI_BYTE_CREDITS)
                else fail_run("the DUT sent a byte while the sink buffer was full");
            end
        end
    end

    always @(negedge clk) begin
        if (byte_valid_o) begin
            assert (rx_count - rx_base < exp_bytes.size())
            else fail_run($sformatf("test %s: the DUT sent more bytes than expected", test_name));
            assert (byte_data_o == exp_bytes[rx_count - rx_base])
            else report_mismatch($sformatf("byte %0d", rx_count - rx_base),
                                 exp_bytes[rx_count - rx_base], byte_data_o);
            rx_count++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic run_image(input string name, input pixel_q_t pixels, input int delay_max);
        logic [31:0] data;
        test_name        = name;
        exp_bytes        = qoi_encode_ref(pixels);
        rx_base          = rx_count;
        credit_delay_max = delay_max;
        write_reg(`QOI_REG_PIXELS, pixels.size());
        write_reg(`QOI_REG_CTRL, 32'd1);
        read_reg(`QOI_REG_STATUS, data);
        check_value("STATUS after start", 1, data);  // busy set, done cleared
        foreach (pixels[i]) begin
            src_pixels.push_back(pixels[i]);
        end
        data = '0;
        while (!data[1]) begin
            read_reg(`QOI_REG_STATUS, data);
        end
        check_value("STATUS at done", 2, data);
        check_value("bytes received", exp_bytes.size(), rx_count - rx_base);
        read_reg(`QOI_REG_BYTES, data);
        check_value("BYTES register", exp_bytes.size(), data);
    endtask

    initial begin
        logic [31:0] data;
        pixel_q_t    img_a;
        pixel_q_t    img_b;
        pixel_q_t    img_u;
        void'($urandom(17));
        test_name   = "reset";
        rst         = 1'b1;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        img_a = palette_image(PALETTE_PIXELS);
        img_b = palette_image(PALETTE_PIXELS);
        for (int i = 0; i < UNIFORM_PIXELS; i++) begin
            img_u.push_back(32'h306090ff);
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        read_reg(`QOI_REG_STATUS, data);
        check_value("STATUS after reset", 0, data);
        write_reg(`QOI_REG_PIXELS, 32'h0000abcd);
        read_reg(`QOI_REG_PIXELS, data);
        check_value("PIXELS readback", 32'h0000abcd, data);
        repeat (20) @(negedge clk);  // the compare process flags any byte sent while idle

        run_image("palette", img_a, 0);
        run_image("uniform", img_u, 0);
        run_image("slow_sink", img_b, 6);
        run_image("restart", img_a, 3);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
+incdir+tb
rtl/qoi_pkg.sv
rtl/qoi_regs.sv
rtl/qoi_credit_fifo.sv
rtl/qoi_classify.sv
rtl/qoi_chunk_serializer.sv
rtl/qoi_encoder_top.sv
tb/tb_qoi_encoder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_qoi_encoder
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/qoi_cfg.svh tb/qoi_ref_model.svh

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
